// ==== fix_seq_pkg.sv ====
package fix_seq_pkg;

   // tuser sideband
   localparam int tuser_w = 128;

   typedef logic [tuser_w-1:0] tuser_t;

   // message type field in tuser
   localparam int msg_type_lo = 48;
   localparam int msg_type_hi = 63;

   // pass-through flag field in tuser
   localparam int pass_lo = 32;
   localparam int pass_hi = 47;

   // counted FIX message types
   localparam logic [15:0] msg_test_req  = 16'h05;
   localparam logic [15:0] msg_heartbeat = 16'h07;

   // flag field value for a frame that is not counted
   localparam logic [15:0] pass_code = 16'h01;

   // sequence number geometry
   localparam int bcd_digits = 8;
   localparam int out_digits = 6;

   typedef logic [3:0] bcd_digit_t;

   // digit 0 sits in the low nibble
   typedef logic [bcd_digits*4-1:0] seq_num_t;

   // low six digits, as queued for the consumer
   typedef logic [out_digits*4-1:0] seq_out_t;

   // sequence numbers start at 00000001
   localparam seq_num_t seq_reset_val = 32'h0000_0001;

   // output queue holds 2**fifo_depth_bits entries
   localparam int fifo_depth_bits = 2;

   typedef enum logic [1:0] {
      st_wait,
      st_pass,
      st_resend
   } fix_state_t;

endpackage

// ==== seq_ctrl_if.sv ====
`timescale 1ns/1ps

interface seq_ctrl_if import fix_seq_pkg::*; ();

   // one-cycle strobes, load wins if both are set
   logic     incr;
   logic     load;
   seq_num_t load_value;

   // current sequence number
   seq_num_t value;

   modport ctrl (
      output incr,
      output load,
      output load_value,
      input  value
   );

   modport counter (
      input  incr,
      input  load,
      input  load_value,
      output value
   );

endinterface

// ==== fix_seq_ctrl.sv ====
`timescale 1ns/1ps

module fix_seq_ctrl import fix_seq_pkg::*; (
   input  logic     clk,
   input  logic     reset,

   input  logic     tvalid,
   input  logic     tlast,
   input  tuser_t   tuser,

   input  logic     resend_mode_one,
   input  logic     resend_mode_two,
   input  logic     resend_mode_three,
   input  seq_num_t fix_resend_num_begin,

   seq_ctrl_if.ctrl ctrl,

   output logic     push,
   output logic     resend_ack
);

   fix_state_t state;
   fix_state_t state_next;

   logic [msg_type_hi-msg_type_lo:0] msg_type;
   logic [pass_hi-pass_lo:0]         pass_field;

   logic frame_end;
   logic counted_end;
   logic pass_hit;
   logic resend_req;
   logic incr_req;
   logic load_req;

   // tuser decode
   assign msg_type   = tuser[msg_type_hi:msg_type_lo];
   assign pass_field = tuser[pass_hi:pass_lo];

   assign frame_end   = tvalid && tlast;
   assign counted_end = frame_end &&
                        (msg_type == msg_test_req || msg_type == msg_heartbeat);
   assign pass_hit    = tvalid && (pass_field == pass_code);

   // all three modes reload from the begin value
   assign resend_req = resend_mode_one || resend_mode_two || resend_mode_three;

   // priority in st_wait: counted end, pass-through, resend
   always_comb begin
      state_next = state;
      incr_req   = 1'b0;
      load_req   = 1'b0;
      case (state)
         st_wait: begin
            if (counted_end) begin
               incr_req = 1'b1;
            end else if (pass_hit) begin
               state_next = st_pass;
            end else if (resend_req) begin
               state_next = st_resend;
            end
         end
         st_pass: begin
            // the closing beat of a pass frame is not counted
            if (frame_end) begin
               state_next = st_wait;
            end
         end
         st_resend: begin
            load_req   = 1'b1;
            state_next = st_wait;
         end
         default: begin
            state_next = st_wait;
         end
      endcase
   end

   assign ctrl.incr       = incr_req;
   assign ctrl.load       = load_req;
   assign ctrl.load_value = fix_resend_num_begin;

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= st_wait;
         push       <= 1'b0;
         resend_ack <= 1'b0;
      end else begin
         state      <= state_next;
         // queue write lands one edge after the counter update
         push       <= frame_end;
         resend_ack <= load_req;
      end
   end

   a_no_incr_with_load: assert property (
      @(posedge clk) disable iff (reset) !(ctrl.incr && ctrl.load))
      else $error("fix_seq_ctrl: incr and load raised together");

   a_ack_one_cycle: assert property (
      @(posedge clk) disable iff (reset) resend_ack |=> !resend_ack)
      else $error("fix_seq_ctrl: resend_ack held for two cycles");

endmodule

// ==== bcd_seq_counter.sv ====
`timescale 1ns/1ps

module bcd_seq_counter import fix_seq_pkg::*; (
   input  logic clk,
   input  logic reset,

   seq_ctrl_if.counter cnt
);

   bcd_digit_t digit     [bcd_digits];
   bcd_digit_t digit_inc [bcd_digits];

   // five bits so that an out-of-range digit plus one does not alias
   logic [4:0] digit_sum [bcd_digits];

   // carry into each digit, digit 0 always gets the +1
   logic [bcd_digits-1:0] carry;

   assign carry[0] = 1'b1;

   genvar g;
   for (g = 0; g < bcd_digits; g++) begin : g_digit
      assign digit_sum[g] = {1'b0, digit[g]} + {4'd0, carry[g]};

      // 10 or more rolls over to 0
      assign digit_inc[g] = (digit_sum[g] >= 5'd10) ? 4'd0 : digit_sum[g][3:0];

      // top digit wraps with no carry out
      if (g < bcd_digits - 1) begin : g_carry
         assign carry[g+1] = (digit_sum[g] >= 5'd10);
      end

      assign cnt.value[4*g +: 4] = digit[g];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < bcd_digits; i++) begin
            digit[i] <= seq_reset_val[4*i +: 4];
         end
      end else if (cnt.load) begin
         // loaded as given, no digit check
         for (int i = 0; i < bcd_digits; i++) begin
            digit[i] <= cnt.load_value[4*i +: 4];
         end
      end else if (cnt.incr) begin
         for (int i = 0; i < bcd_digits; i++) begin
            digit[i] <= digit_inc[i];
         end
      end
   end

endmodule

// ==== seq_num_fifo.sv ====
`timescale 1ns/1ps

module seq_num_fifo import fix_seq_pkg::*; (
   input  logic     clk,
   input  logic     reset,

   input  logic     push,
   input  seq_out_t din,

   input  logic     pop,
   output seq_out_t dout,
   output logic     not_empty
);

   localparam int depth = 2 ** fifo_depth_bits;

   seq_out_t mem [depth];

   logic [fifo_depth_bits-1:0] wr_ptr;
   logic [fifo_depth_bits-1:0] rd_ptr;
   logic [fifo_depth_bits:0]   count;

   logic full;
   logic wr_ok;
   logic rd_ok;

   assign full      = (count == depth[fifo_depth_bits:0]);
   assign not_empty = (count != '0);

   // a push into a full queue is dropped
   assign wr_ok = push && !full;
   assign rd_ok = pop && not_empty;

   // fallthrough, head entry always visible
   assign dout = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_pop_empty: assert property (
      @(posedge clk) disable iff (reset) pop |-> not_empty)
      else $error("seq_num_fifo: pop while empty");

   a_no_push_full: assert property (
      @(posedge clk) disable iff (reset) push |-> !full)
      else $error("seq_num_fifo: push while full, sequence number lost");

endmodule

// ==== fix_seq_number_top.sv ====
`timescale 1ns/1ps

module fix_seq_number_top import fix_seq_pkg::*; (
   input  logic     clk,
   input  logic     reset,

   // packet stream, sideband only
   input  logic     tvalid,
   input  logic     tlast,
   input  tuser_t   tuser,

   // resend request
   input  logic     resend_mode_one,
   input  logic     resend_mode_two,
   input  logic     resend_mode_three,
   input  seq_num_t fix_resend_num_begin,
   output logic     resend_ack,

   // queued sequence numbers
   output logic     fix_seq_num_vld,
   output seq_out_t fix_new_seq_num,
   input  logic     rd_fix_seq_num
);

   seq_ctrl_if seq_ctrl_bus ();

   logic     push;
   seq_out_t fifo_din;

   // only the low six digits are queued
   assign fifo_din = seq_ctrl_bus.value[$bits(seq_out_t)-1:0];

   fix_seq_ctrl fix_seq_ctrl_i (
      .clk                  (clk),
      .reset                (reset),
      .tvalid               (tvalid),
      .tlast                (tlast),
      .tuser                (tuser),
      .resend_mode_one      (resend_mode_one),
      .resend_mode_two      (resend_mode_two),
      .resend_mode_three    (resend_mode_three),
      .fix_resend_num_begin (fix_resend_num_begin),
      .ctrl                 (seq_ctrl_bus.ctrl),
      .push                 (push),
      .resend_ack           (resend_ack)
   );

   bcd_seq_counter bcd_seq_counter_i (
      .clk   (clk),
      .reset (reset),
      .cnt   (seq_ctrl_bus.counter)
   );

   seq_num_fifo seq_num_fifo_i (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .din       (fifo_din),
      .pop       (rd_fix_seq_num),
      .dout      (fix_new_seq_num),
      .not_empty (fix_seq_num_vld)
   );

endmodule

// ==== tb_fix_seq_number.sv ====
`timescale 1ns/1ps

module tb_fix_seq_number import fix_seq_pkg::*; ();

   localparam int reset_cycles  = 10;
   localparam int n_rand_frames = 150;
   // beats plus gaps, drained frames, resend sequences, final drain
   localparam int gen_cycles  = reset_cycles + n_rand_frames * 6 + 8 * 8 + 4 * 10 + 10;
   localparam int cycle_limit = gen_cycles + 200;

   logic     clk;
   logic     reset;
   logic     tvalid;
   logic     tlast;
   tuser_t   tuser;
   logic     resend_mode_one;
   logic     resend_mode_two;
   logic     resend_mode_three;
   seq_num_t fix_resend_num_begin;
   logic     rd_fix_seq_num;
   logic     resend_ack;
   logic     fix_seq_num_vld;
   seq_out_t fix_new_seq_num;

   // reference model state
   fix_state_t m_state;
   seq_num_t   m_num;
   logic       m_ack;
   seq_out_t   exp_q[$];
   seq_out_t   last_popped;
   int         pop_count;

   int errors;
   int checks;
   int test_err_start;
   int cycle_count;

   fix_seq_number_top fix_seq_number_top_i (
      .clk                  (clk),
      .reset                (reset),
      .tvalid               (tvalid),
      .tlast                (tlast),
      .tuser                (tuser),
      .resend_mode_one      (resend_mode_one),
      .resend_mode_two      (resend_mode_two),
      .resend_mode_three    (resend_mode_three),
      .fix_resend_num_begin (fix_resend_num_begin),
      .resend_ack           (resend_ack),
      .fix_seq_num_vld      (fix_seq_num_vld),
      .fix_new_seq_num      (fix_new_seq_num),
      .rd_fix_seq_num       (rd_fix_seq_num)
   );

   always #4 clk = ~clk;

   // digit-wise +1, a digit of 10 or more becomes 0 and carries
   function automatic seq_num_t bcd_inc(input seq_num_t v);
      seq_num_t r;
      int       d;
      int       carry;
      r     = v;
      carry = 1;
      for (int i = 0; i < bcd_digits; i++) begin
         d = int'(v[4*i +: 4]) + carry;
         carry = (d >= 10) ? 1 : 0;
         r[4*i +: 4] = (d >= 10) ? 4'd0 : 4'(d);
      end
      return r;
   endfunction

   function automatic seq_num_t random_bcd();
      seq_num_t v;
      for (int i = 0; i < bcd_digits; i++) begin
         v[4*i +: 4] = 4'($urandom % 10);
      end
      return v;
   endfunction

   task automatic check_equal(input string sig, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("mismatch %s: got %h, expected %h", sig, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      if (errors == test_err_start) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - test_err_start);
      end
      test_err_start = errors;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         tvalid = 1'b0;
         tlast  = 1'b0;
      end
   endtask

   // kind 0 test request, 1 heartbeat, 2 other type, 3 pass-through ending in 05
   task automatic send_frame(input int len, input int kind);
      tuser_t      u;
      logic [15:0] ty;
      int unsigned r;
      for (int i = 0; i < len; i++) begin
         @(negedge clk);
         u = {$urandom, $urandom, $urandom, $urandom};
         r = $urandom;
         case (kind)
            0, 3:    ty = msg_test_req;
            1:       ty = msg_heartbeat;
            default: ty = r[15:0];
         endcase
         if (kind == 2 && (ty == msg_test_req || ty == msg_heartbeat)) begin
            ty = 16'h0041;
         end
         u[msg_type_hi:msg_type_lo] = ty;
         u[pass_hi:pass_lo] = (kind == 3) ? pass_code : 16'h0000;
         tvalid = 1'b1;
         tlast  = (i == len - 1);
         tuser  = u;
      end
   endtask

   task automatic wait_drain();
      idle_cycles(1);
      while (exp_q.size() != 0 || fix_seq_num_vld) begin
         @(negedge clk);
      end
   endtask

   task automatic issue_resend(input int mode, input seq_num_t begin_val);
      wait_drain();
      @(negedge clk);
      fix_resend_num_begin = begin_val;
      resend_mode_one      = (mode == 0);
      resend_mode_two      = (mode == 1);
      resend_mode_three    = (mode == 2);
      @(negedge clk);
      resend_mode_one   = 1'b0;
      resend_mode_two   = 1'b0;
      resend_mode_three = 1'b0;
      check_equal("resend_ack", 32'(resend_ack), 32'd0);
      @(negedge clk);
      check_equal("resend_ack", 32'(resend_ack), 32'd1);
      check_equal("fix_seq_num_vld", 32'(fix_seq_num_vld), 32'd0);
      @(negedge clk);
      check_equal("resend_ack", 32'(resend_ack), 32'd0);
      // no frame end yet, so nothing may be queued
      repeat (3) begin
         @(negedge clk);
         check_equal("fix_seq_num_vld", 32'(fix_seq_num_vld), 32'd0);
      end
   endtask

   // model of the control FSM and counter, stepped on every edge
   always @(posedge clk) begin : model
      logic        fe;
      logic        counted;
      logic        pass;
      logic        rs;
      logic [15:0] ty;
      if (reset) begin
         m_state = st_wait;
         m_num   = seq_reset_val;
         m_ack   = 1'b0;
         exp_q.delete();
      end else begin
         fe      = tvalid && tlast;
         ty      = tuser[msg_type_hi:msg_type_lo];
         counted = fe && (ty == 16'h0005 || ty == 16'h0007);
         pass    = tvalid && (tuser[pass_hi:pass_lo] == 16'h0001);
         rs      = resend_mode_one || resend_mode_two || resend_mode_three;
         m_ack   = (m_state == st_resend);
         case (m_state)
            st_wait: begin
               if (counted) begin
                  m_num = bcd_inc(m_num);
               end else if (pass) begin
                  m_state = st_pass;
               end else if (rs) begin
                  m_state = st_resend;
               end
            end
            st_pass: begin
               if (fe) begin
                  m_state = st_wait;
               end
            end
            default: begin
               m_num   = fix_resend_num_begin;
               m_state = st_wait;
            end
         endcase
         if (fe) begin
            exp_q.push_back(m_num[$bits(seq_out_t)-1:0]);
         end
      end
   end

   // pop whenever an entry is visible and compare it with the model queue
   always @(negedge clk) begin
      if (reset) begin
         rd_fix_seq_num = 1'b0;
      end else begin
         check_equal("resend_ack", 32'(resend_ack), 32'(m_ack));
         if (fix_seq_num_vld) begin
            checks++;
            assert (exp_q.size() != 0) else begin
               $display("fix_seq_num_vld is high but no sequence number was expected");
               errors++;
            end
            if (exp_q.size() != 0) begin
               check_equal("fix_new_seq_num", 32'(fix_new_seq_num), 32'(exp_q[0]));
               void'(exp_q.pop_front());
            end
            last_popped    = fix_new_seq_num;
            pop_count      = pop_count + 1;
            rd_fix_seq_num = 1'b1;
         end else begin
            rd_fix_seq_num = 1'b0;
         end
      end
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Result: FAILED");
         $finish;
      end
   end

   initial begin : stimulus
      int       len;
      int       kind;
      int       pops;
      seq_out_t prev;
      seq_num_t begin_val;
      seq_num_t next_val;
      void'($urandom(8897));
      clk                  = 1'b0;
      reset                = 1'b1;
      tvalid               = 1'b0;
      tlast                = 1'b0;
      tuser                = '0;
      resend_mode_one      = 1'b0;
      resend_mode_two      = 1'b0;
      resend_mode_three    = 1'b0;
      fix_resend_num_begin = '0;
      rd_fix_seq_num       = 1'b0;
      errors               = 0;
      checks               = 0;
      test_err_start       = 0;
      cycle_count          = 0;
      pop_count            = 0;
      last_popped          = '0;
      repeat (reset_cycles) @(negedge clk);
      reset = 1'b0;

      @(negedge clk);
      check_equal("fix_seq_num_vld", 32'(fix_seq_num_vld), 32'd0);
      check_equal("resend_ack", 32'(resend_ack), 32'd0);
      send_frame(1, 0);
      wait_drain();
      check_equal("fix_new_seq_num", 32'(last_popped), 32'h000002);
      finish_test("reset_and_first_count");

      for (int f = 0; f < n_rand_frames; f++) begin
         kind = int'($urandom % 4);
         len  = (kind == 3) ? 2 + int'($urandom % 3) : 1 + int'($urandom % 4);
         send_frame(len, kind);
         idle_cycles(int'($urandom % 3));
      end
      wait_drain();
      finish_test("random_frames");

      // high digits fall off the queued value
      issue_resend(0, 32'h0099_9999);
      send_frame(1, 0);
      wait_drain();
      check_equal("fix_new_seq_num", 32'(last_popped), 32'h000000);
      send_frame(1, 2);
      wait_drain();
      check_equal("fix_new_seq_num", 32'(last_popped), 32'h000000);
      finish_test("bcd_carry");

      send_frame(1, 2);
      wait_drain();
      prev = m_num[$bits(seq_out_t)-1:0];
      pops = pop_count;
      send_frame(2, 3);
      wait_drain();
      check_equal("fix_new_seq_num", 32'(last_popped), 32'(prev));
      check_equal("pop_count", 32'(pop_count), 32'(pops + 1));
      finish_test("pass_through");

      for (int m = 0; m < 3; m++) begin
         begin_val = random_bcd();
         issue_resend(m, begin_val);
         send_frame(1, m % 2);
         wait_drain();
         next_val = bcd_inc(begin_val);
         check_equal("fix_new_seq_num", 32'(last_popped), 32'(next_val[23:0]));
      end
      finish_test("resend_modes");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== src.f ====
fix_seq_pkg.sv
seq_ctrl_if.sv
fix_seq_ctrl.sv
bcd_seq_counter.sv
seq_num_fifo.sv
fix_seq_number_top.sv
tb_fix_seq_number.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir
verilator --binary --timing --top-module tb_fix_seq_number -f src.f -o tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
